//--- Makefile
# Verilator build, run, lint and clean for the vector element unit

VERILATOR ?= verilator
TOP       ?= vec_elem_unit_tb
RTL_TOP   ?= vec_elem_unit
FILELIST  ?= vec_elem_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/elem_op_stage.sv
/*
 * Element operation stage: move-to-scalar, compress and index,
 * with the running element index of the current instruction
 */
`timescale 1ns/1ps
`default_nettype none

module elem_op_stage (
        input  wire logic                   clk_i,
        input  wire logic                   async_rst_ni,
        input  wire vec_elem_pkg::elem_in_t in_i,
        input  wire logic                   fire_i,
        output vec_elem_pkg::elem_out_t     out_o
);

        import vec_elem_pkg::*;

        logic [ELEM_IDX_W-1:0] idx_q;
        logic [ELEM_IDX_W-1:0] idx_cur;

        // Index restarts with each instruction
        assign idx_cur = in_i.ctrl.first_cycle ? '0 : idx_q;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        idx_q <= '0;
                end else if (fire_i) begin
                        idx_q <= idx_cur + ELEM_IDX_W'(1);
                end
        end

        always_comb begin
                out_o.ctrl       = in_i.ctrl;
                out_o.res_valid  = 1'b0;
                out_o.xreg_valid = 1'b0;
                out_o.result     = in_i.operand;
                unique case (in_i.ctrl.op)
                        ELEM_XMV: begin
                                out_o.xreg_valid = in_i.ctrl.first_cycle;   // Element 0 only
                        end
                        ELEM_COMPRESS: begin
                                out_o.res_valid  = in_i.mask;
                        end
                        ELEM_INDEX: begin
                                out_o.res_valid  = 1'b1;
                                out_o.result     = ELEM_W'(idx_cur);
                        end
                        default: begin
                                out_o.result     = '0;
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- logic/elem_result_packer.sv
/*
 * Result packer: tracks bytes written to the destination group, derives
 * store/shift flags and vreg address, pads compress results, speculation
 */
`timescale 1ns/1ps
`default_nettype none

module elem_result_packer (
        input  wire logic                                 clk_i,
        input  wire logic                                 async_rst_ni,

        input  wire logic                                 in_valid_i,
        output logic                                      in_ready_o,
        input  wire vec_elem_pkg::elem_out_t              in_i,

        output logic                                      out_valid_o,
        input  wire logic                                 out_ready_i,
        output vec_elem_pkg::res_beat_t                   beat_o,

        output logic                                      xreg_valid_o,
        output vec_elem_pkg::xreg_wb_t                    xreg_o,

        input  wire logic [vec_elem_pkg::ID_CNT-1:0]      instr_spec_i,
        input  wire logic [vec_elem_pkg::ID_CNT-1:0]      instr_killed_i
);

        import vec_elem_pkg::*;

        logic                  flushing_q, flushing_d;
        logic                  has_res_q,  has_res_d;
        logic [VD_CNT_W-1:0]   cnt_q,      cnt_d;
        logic [ID_W-1:0]       flush_id_q;
        vsew_e                 flush_eew_q;
        emul_e                 flush_emul_q;
        logic [4:0]            flush_vaddr_q;

        logic                  xfer;
        logic                  stall;
        logic                  first_res;
        logic                  flush_last;
        vsew_e                 cur_eew;
        emul_e                 cur_emul;
        logic [4:0]            base_vaddr;
        logic [VD_CNT_W-1:0]   step;
        logic [CNT_MUL_W-1:0]  cnt_mul;

        assign cur_eew    = flushing_q ? flush_eew_q   : in_i.ctrl.eew;
        assign cur_emul   = flushing_q ? flush_emul_q  : in_i.ctrl.emul;
        assign base_vaddr = flushing_q ? flush_vaddr_q : in_i.ctrl.vaddr;

        always_comb begin
                unique case (cur_eew)
                        VSEW_8:  step = VD_CNT_W'(1);
                        VSEW_16: step = VD_CNT_W'(2);
                        default: step = VD_CNT_W'(4);
                endcase
        end

        // Scalar move waits until its instruction is no longer speculative
        assign stall       = in_i.xreg_valid & instr_spec_i[in_i.ctrl.id];
        assign out_valid_o = flushing_q | (in_valid_i & ~stall);
        assign in_ready_o  = out_ready_i & ~flushing_q & ~stall;
        assign xfer        = out_valid_o & out_ready_i;

        assign first_res = ~flushing_q & in_i.res_valid & (in_i.ctrl.first_cycle | ~has_res_q);

        always_comb begin
                has_res_d = has_res_q;
                if (in_i.ctrl.first_cycle) begin
                        has_res_d = 1'b0;
                end
                if (in_i.res_valid) begin
                        has_res_d = 1'b1;
                end
        end

        always_comb begin
                cnt_d = cnt_q;
                if (flushing_q | in_i.res_valid) begin
                        cnt_d = cnt_q + step;
                end
                if (first_res) begin
                        cnt_d = step - VD_CNT_W'(1);            // Last byte of element 0
                end
        end
        assign cnt_mul = cnt_d[VD_CNT_W-1:CNT_LOW_W];

        always_comb begin
                flushing_d = flushing_q;
                flush_last = 1'b0;
                if (~flushing_q & in_i.ctrl.last_cycle & in_i.ctrl.requires_flush) begin
                        flushing_d = 1'b1;
                end
                if (flushing_q & (cnt_d[CNT_LOW_W-1:0] == '1)) begin
                        flushing_d = 1'b0;
                        flush_last = 1'b1;
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        flushing_q <= 1'b0;
                        has_res_q  <= 1'b0;
                        cnt_q      <= '0;
                end else if (xfer) begin
                        flushing_q <= flushing_d;
                        cnt_q      <= cnt_d;
                        if (~flushing_q) begin
                                has_res_q <= has_res_d;
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (xfer & ~flushing_q & in_i.ctrl.last_cycle & in_i.ctrl.requires_flush) begin
                        flush_id_q    <= in_i.ctrl.id;
                        flush_eew_q   <= in_i.ctrl.eew;
                        flush_emul_q  <= in_i.ctrl.emul;
                        flush_vaddr_q <= in_i.ctrl.vaddr;
                end
        end

        always_comb begin
                beat_o.id        = flushing_q ? flush_id_q : in_i.ctrl.id;
                beat_o.eew       = cur_eew;
                unique case (cur_emul)
                        EMUL_1:  beat_o.vaddr = base_vaddr;
                        EMUL_2:  beat_o.vaddr = base_vaddr | {4'b0, cnt_mul[0]};
                        EMUL_4:  beat_o.vaddr = base_vaddr | {3'b0, cnt_mul[1:0]};
                        default: beat_o.vaddr = base_vaddr | {2'b0, cnt_mul[2:0]};
                endcase
                unique case (cur_eew)
                        VSEW_8:  beat_o.shift = cnt_d[1:0] == 2'b00;
                        VSEW_16: beat_o.shift = ~cnt_d[1];
                        default: beat_o.shift = 1'b1;   // Every 32-bit result fills a word
                endcase
                beat_o.res_store = (((in_i.ctrl.op != ELEM_XMV) & in_i.res_valid) | flushing_q)
                                   & (cnt_d[CNT_LOW_W-1:0] == '1);
                beat_o.res_valid = flushing_q | in_i.res_valid;
                beat_o.data      = flushing_q ? '0 : in_i.result;  // Next element may load meanwhile
                unique case (cur_eew)
                        VSEW_8:  beat_o.mask = 4'b0001;
                        VSEW_16: beat_o.mask = 4'b0011;
                        default: beat_o.mask = 4'b1111;
                endcase
                if (flushing_q | ~in_i.res_valid) begin
                        beat_o.mask = '0;               // Padding writes nothing
                end
                beat_o.instr_done     = (~flushing_q & in_i.ctrl.last_cycle
                                         & ~in_i.ctrl.requires_flush) | flush_last;
                beat_o.pend_clear     = (~flushing_q & in_i.ctrl.last_cycle
                                         & ~in_i.ctrl.requires_flush
                                         & (in_i.ctrl.op != ELEM_XMV)) | flush_last;
                beat_o.pend_clear_cnt = cur_emul;
        end

        assign xreg_valid_o = in_valid_i & in_i.xreg_valid & ~stall & ~flushing_q
                              & ~instr_killed_i[in_i.ctrl.id] & out_ready_i;
        assign xreg_o.id    = in_i.ctrl.id;
        assign xreg_o.addr  = in_i.ctrl.xreg_addr;
        assign xreg_o.data  = in_i.result;

endmodule

`default_nettype wire

//--- logic/pipe_reg.sv
/*
 * Single-entry valid/ready pipeline register for an arbitrary payload type
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
        parameter type PAYLOAD_T = logic
) (
        input  wire logic     clk_i,
        input  wire logic     async_rst_ni,

        input  wire logic     in_valid_i,
        output logic          in_ready_o,
        input  wire PAYLOAD_T in_data_i,

        output logic          out_valid_o,
        input  wire logic     out_ready_i,
        output PAYLOAD_T      out_data_o
);

        logic     valid_q;
        PAYLOAD_T data_q;

        assign in_ready_o  = ~valid_q | out_ready_i;      // Empty or draining this cycle
        assign out_valid_o = valid_q;
        assign out_data_o  = data_q;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        valid_q <= 1'b0;
                end else if (in_ready_o) begin
                        valid_q <= in_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_ready_o & in_valid_i) begin
                        data_q <= in_data_i;
                end
        end

endmodule

`default_nettype wire

//--- logic/vec_elem_pkg.sv
/*
 * Vector element unit package: widths, encodings and the payload structs
 * passed between the pipeline stages
 */
`default_nettype none

package vec_elem_pkg;

        localparam int unsigned VREG_W     = 64;                    // Vector register width
        localparam int unsigned ELEM_W     = 32;                    // Element and result width
        localparam int unsigned ID_W       = 3;
        localparam int unsigned ID_CNT     = 8;
        localparam int unsigned CNT_LOW_W  = $clog2(VREG_W / 8);   // Byte offset in one vreg
        localparam int unsigned CNT_MUL_W  = 3;                     // Vreg index in a group
        localparam int unsigned VD_CNT_W   = CNT_MUL_W + CNT_LOW_W;
        localparam int unsigned ELEM_IDX_W = CNT_MUL_W + CNT_LOW_W; // Up to 64 elements

        typedef enum logic [1:0] {
                VSEW_8  = 2'b00,
                VSEW_16 = 2'b01,
                VSEW_32 = 2'b10
        } vsew_e;

        typedef enum logic [1:0] {
                EMUL_1 = 2'b00,
                EMUL_2 = 2'b01,
                EMUL_4 = 2'b10,
                EMUL_8 = 2'b11
        } emul_e;

        typedef enum logic [1:0] {
                ELEM_XMV      = 2'b00,                              // Move element to x reg
                ELEM_COMPRESS = 2'b01,
                ELEM_INDEX    = 2'b10
        } elem_op_e;

        typedef struct packed {
                logic [ID_W-1:0] id;
                vsew_e           eew;
                emul_e           emul;
                elem_op_e        op;
                logic [4:0]      vaddr;                             // Base of destination group
                logic [4:0]      xreg_addr;
                logic            first_cycle;
                logic            last_cycle;
                logic            requires_flush;                    // Compress only
        } elem_ctrl_t;

        typedef struct packed {
                elem_ctrl_t        ctrl;
                logic [ELEM_W-1:0] operand;
                logic              mask;
        } elem_in_t;

        typedef struct packed {
                elem_ctrl_t        ctrl;
                logic              res_valid;
                logic              xreg_valid;
                logic [ELEM_W-1:0] result;
        } elem_out_t;

        typedef struct packed {
                logic [ID_W-1:0]     id;
                vsew_e               eew;
                logic [4:0]          vaddr;
                logic                res_valid;
                logic                res_store;
                logic                shift;
                logic [ELEM_W-1:0]   data;
                logic [ELEM_W/8-1:0] mask;
                logic                instr_done;
                logic                pend_clear;
                logic [1:0]          pend_clear_cnt;
        } res_beat_t;

        typedef struct packed {
                logic [ID_W-1:0]   id;
                logic [4:0]        addr;
                logic [ELEM_W-1:0] data;
        } xreg_wb_t;

endpackage

`default_nettype wire

//--- logic/vec_elem_unit.sv
/*
 * Vector element result path: input register, element op, output register
 * and result packer
 */
`timescale 1ns/1ps
`default_nettype none

module vec_elem_unit (
        input  wire logic                            clk_i,
        input  wire logic                            async_rst_ni,

        input  wire logic                            pipe_in_valid_i,
        output logic                                 pipe_in_ready_o,
        input  wire vec_elem_pkg::elem_in_t          pipe_in_i,

        output logic                                 pipe_out_valid_o,
        input  wire logic                            pipe_out_ready_i,
        output vec_elem_pkg::res_beat_t              pipe_out_o,

        output logic                                 xreg_valid_o,
        output vec_elem_pkg::xreg_wb_t               xreg_o,

        input  wire logic [vec_elem_pkg::ID_CNT-1:0] instr_spec_i,
        input  wire logic [vec_elem_pkg::ID_CNT-1:0] instr_killed_i
);

        import vec_elem_pkg::*;

        logic      op_valid, op_ready, op_fire;
        elem_in_t  op_in;
        elem_out_t op_out;
        logic      pk_valid, pk_ready;
        elem_out_t pk_in;

        pipe_reg #(.PAYLOAD_T(elem_in_t)) in_reg (
                .clk_i        ( clk_i           ),
                .async_rst_ni ( async_rst_ni    ),
                .in_valid_i   ( pipe_in_valid_i ),
                .in_ready_o   ( pipe_in_ready_o ),
                .in_data_i    ( pipe_in_i       ),
                .out_valid_o  ( op_valid        ),
                .out_ready_i  ( op_ready        ),
                .out_data_o   ( op_in           )
        );

        assign op_fire = op_valid & op_ready;   // Element enters the output register

        elem_op_stage op_stage (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .in_i         ( op_in        ),
                .fire_i       ( op_fire      ),
                .out_o        ( op_out       )
        );

        pipe_reg #(.PAYLOAD_T(elem_out_t)) out_reg (
                .clk_i        ( clk_i        ),
                .async_rst_ni ( async_rst_ni ),
                .in_valid_i   ( op_valid     ),
                .in_ready_o   ( op_ready     ),
                .in_data_i    ( op_out       ),
                .out_valid_o  ( pk_valid     ),
                .out_ready_i  ( pk_ready     ),
                .out_data_o   ( pk_in        )
        );

        elem_result_packer packer (
                .clk_i          ( clk_i            ),
                .async_rst_ni   ( async_rst_ni     ),
                .in_valid_i     ( pk_valid         ),
                .in_ready_o     ( pk_ready         ),
                .in_i           ( pk_in            ),
                .out_valid_o    ( pipe_out_valid_o ),
                .out_ready_i    ( pipe_out_ready_i ),
                .beat_o         ( pipe_out_o       ),
                .xreg_valid_o   ( xreg_valid_o     ),
                .xreg_o         ( xreg_o           ),
                .instr_spec_i   ( instr_spec_i     ),
                .instr_killed_i ( instr_killed_i   )
        );

endmodule

`default_nettype wire

//--- test/vec_elem_unit_sva.sv
/*
 * Handshake and reset assertions for the vector element unit
 */
`timescale 1ns/1ps
`default_nettype none

module vec_elem_unit_sva (
        input wire logic                            clk_i,
        input wire logic                            async_rst_ni,
        input wire logic                            pipe_in_valid_i,
        input wire logic                            pipe_in_ready_o,
        input wire vec_elem_pkg::elem_in_t          pipe_in_i,
        input wire logic                            pipe_out_valid_o,
        input wire logic                            pipe_out_ready_i,
        input wire vec_elem_pkg::res_beat_t         pipe_out_o,
        input wire logic                            xreg_valid_o,
        input wire logic [vec_elem_pkg::ID_CNT-1:0] instr_spec_i
);

        in_held: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                pipe_in_valid_i && !pipe_in_ready_o |=> pipe_in_valid_i && $stable(pipe_in_i))
                else $error("input element changed before it was accepted");

        // A beat only drops back while its scalar move turns speculative
        out_held: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                pipe_out_valid_o && !pipe_out_ready_i |=> $stable(pipe_out_o)
                && (pipe_out_valid_o || instr_spec_i[pipe_out_o.id]))
                else $error("output beat changed before it was taken");

        xreg_on_xfer: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                xreg_valid_o |-> pipe_out_valid_o && pipe_out_ready_i)
                else $error("scalar write-back without an output transfer");

        reset_quiet: assert property (@(posedge clk_i)
                (!async_rst_ni || $rose(async_rst_ni)) |-> !pipe_out_valid_o && !xreg_valid_o)
                else $error("valid outputs high in or right after reset");

endmodule

bind vec_elem_unit vec_elem_unit_sva sva0 (.*);

`default_nettype wire

//--- test/vec_elem_unit_tb.sv
/*
 * Testbench for the vector element unit: random instruction stream,
 * in-order beat model and scalar write-back checks
 */
`timescale 1ns/1ps
`default_nettype none

module vec_elem_unit_tb;

        import vec_elem_pkg::*;

        localparam int unsigned NUM_INSTR = 60;
        localparam int unsigned MAX_LEN   = 12;
        localparam logic [31:0] SEED      = 32'he59150ab;

        logic              clk_i;
        logic              async_rst_ni;
        logic              pipe_in_valid_i;
        logic              pipe_in_ready_o;
        elem_in_t          pipe_in_i;
        logic              pipe_out_valid_o;
        logic              pipe_out_ready_i;
        res_beat_t         pipe_out_o;
        logic              xreg_valid_o;
        xreg_wb_t          xreg_o;
        logic [ID_CNT-1:0] instr_spec_i;
        logic [ID_CNT-1:0] instr_killed_i;

        elem_in_t   in_q[$];                    // Elements in issue order
        res_beat_t  beat_q[$];                  // Expected beats, padding included
        bit         pad_q[$];
        bit         xmv_q[$];                   // Beat carries a scalar write-back
        xreg_wb_t   xreg_q[$];

        logic [5:0] m_cnt;                      // Model byte counter over the group
        bit         m_has_res;
        int         in_idx;
        int         errors;
        int         beats;
        int         cycles;
        int         limit;
        bit         timed_out;
        bit         in_fire;
        bit         out_fire;

        vec_elem_unit dut0 (
                .clk_i            ( clk_i            ),
                .async_rst_ni     ( async_rst_ni     ),
                .pipe_in_valid_i  ( pipe_in_valid_i  ),
                .pipe_in_ready_o  ( pipe_in_ready_o  ),
                .pipe_in_i        ( pipe_in_i        ),
                .pipe_out_valid_o ( pipe_out_valid_o ),
                .pipe_out_ready_i ( pipe_out_ready_i ),
                .pipe_out_o       ( pipe_out_o       ),
                .xreg_valid_o     ( xreg_valid_o     ),
                .xreg_o           ( xreg_o           ),
                .instr_spec_i     ( instr_spec_i     ),
                .instr_killed_i   ( instr_killed_i   )
        );

        function automatic logic [5:0] elem_bytes(input vsew_e eew);
                case (eew)
                        VSEW_8:  return 6'd1;
                        VSEW_16: return 6'd2;
                        default: return 6'd4;
                endcase
        endfunction

        // Flags and register address for a beat that leaves the count at cnt
        function automatic res_beat_t beat_flags(input vsew_e eew, input emul_e emul,
                                                 input logic [4:0] base, input logic [5:0] cnt,
                                                 input bit can_store);
                res_beat_t  b;
                logic [4:0] grp_mask;
                b = '0;
                grp_mask         = (5'd1 << emul) - 5'd1;
                b.eew            = eew;
                b.vaddr          = base | ({2'b0, cnt[5:3]} & grp_mask);
                b.res_store      = can_store && (cnt[2:0] == 3'b111);
                b.shift          = {4'b0, cnt[1:0]} < elem_bytes(eew);  // Starts a new word
                b.pend_clear_cnt = emul;
                return b;
        endfunction

        task automatic push_beat(input res_beat_t b, input bit pad, input bit xmv,
                                 input xreg_wb_t x);
                beat_q.push_back(b);
                pad_q.push_back(pad);
                xmv_q.push_back(xmv);
                xreg_q.push_back(x);
        endtask

        task automatic predict_elem(input elem_in_t e, input int unsigned pos);
                res_beat_t  b;
                xreg_wb_t   x;
                logic [5:0] bytes;
                bit         rv;
                bytes = elem_bytes(e.ctrl.eew);
                rv    = (e.ctrl.op == ELEM_INDEX) || ((e.ctrl.op == ELEM_COMPRESS) && e.mask);
                if (rv && (e.ctrl.first_cycle || !m_has_res)) begin
                        m_cnt = bytes - 6'd1;                   // Last byte of the first result
                end else if (rv) begin
                        m_cnt = m_cnt + bytes;
                end
                if (e.ctrl.first_cycle) begin
                        m_has_res = 1'b0;
                end
                if (rv) begin
                        m_has_res = 1'b1;
                end
                b            = beat_flags(e.ctrl.eew, e.ctrl.emul, e.ctrl.vaddr, m_cnt, rv);
                b.id         = e.ctrl.id;
                b.res_valid  = rv;
                b.data       = (e.ctrl.op == ELEM_INDEX) ? 32'(pos) : e.operand;
                b.mask       = rv ? 4'((32'd1 << bytes) - 32'd1) : 4'b0;
                b.instr_done = e.ctrl.last_cycle && (e.ctrl.op != ELEM_COMPRESS);
                b.pend_clear = e.ctrl.last_cycle && (e.ctrl.op == ELEM_INDEX);
                x.id         = e.ctrl.id;
                x.addr       = e.ctrl.xreg_addr;
                x.data       = e.operand;
                push_beat(b, 1'b0, (e.ctrl.op == ELEM_XMV) && e.ctrl.first_cycle, x);
                if (e.ctrl.last_cycle && (e.ctrl.op == ELEM_COMPRESS)) begin
                        do begin                                // Pad out the current register
                                m_cnt        = m_cnt + bytes;
                                b            = beat_flags(e.ctrl.eew, e.ctrl.emul,
                                                          e.ctrl.vaddr, m_cnt, 1'b1);
                                b.id         = e.ctrl.id;
                                b.res_valid  = 1'b1;
                                b.instr_done = (m_cnt[2:0] == 3'b111);
                                b.pend_clear = b.instr_done;
                                push_beat(b, 1'b1, 1'b0, x);
                        end while (m_cnt[2:0] != 3'b111);
                end
        endtask

        task automatic build_stream();
                elem_in_t    e;
                elem_op_e    op;
                emul_e       emul;
                int unsigned len;
                int unsigned n;
                int unsigned i;
                for (n = 0; n < NUM_INSTR; n++) begin
                        op   = elem_op_e'(2'($urandom_range(2, 0)));
                        emul = emul_e'(2'($urandom));
                        len  = $urandom_range(MAX_LEN, 1);
                        e    = '0;
                        e.ctrl.id             = 3'($urandom);
                        e.ctrl.op             = op;
                        e.ctrl.eew            = vsew_e'(2'($urandom_range(2, 0)));
                        e.ctrl.emul           = emul;
                        e.ctrl.vaddr          = 5'($urandom) & ~((5'd1 << emul) - 5'd1);
                        e.ctrl.xreg_addr      = 5'($urandom);
                        e.ctrl.requires_flush = (op == ELEM_COMPRESS);
                        for (i = 0; i < len; i++) begin
                                e.ctrl.first_cycle = (i == 0);
                                e.ctrl.last_cycle  = (i == len - 1);
                                e.operand          = $urandom;
                                e.mask             = 1'($urandom);
                                in_q.push_back(e);
                                predict_elem(e, i);
                        end
                end
        endtask

        task automatic check_val(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
                if (got !== expected) begin
                        errors++;
                        $display("mismatch at %0t ns: %s got %0h, expected %0h",
                                 $time, name, got, expected);
                end
        endtask

        task automatic check_outputs(input bit fire);
                res_beat_t got;
                res_beat_t exp_b;
                xreg_wb_t  x;
                bit        pad;
                bit        xmv;
                bit        exp_xv;
                exp_xv = 1'b0;
                x      = '0;
                if (fire && (beat_q.size() == 0)) begin
                        errors++;
                        $display("output beat at %0t ns with none expected", $time);
                end else if (fire) begin
                        exp_b = beat_q.pop_front();
                        pad   = pad_q.pop_front();
                        xmv   = xmv_q.pop_front();
                        x     = xreg_q.pop_front();
                        got   = pipe_out_o;
                        if (!pad) begin
                                check_val("pipe_out_o.data", 64'(got.data), 64'(exp_b.data));
                        end
                        got.data   = '0;                        // Padding carries no element
                        exp_b.data = '0;
                        check_val("pipe_out_o", 64'(got), 64'(exp_b));
                        if (xmv && instr_spec_i[exp_b.id]) begin
                                errors++;
                                $display("scalar move left at %0t ns while speculative", $time);
                        end
                        exp_xv = xmv && !instr_killed_i[exp_b.id];
                        beats++;
                end
                check_val("xreg_valid_o", 64'(xreg_valid_o), 64'(exp_xv));
                if (exp_xv) begin
                        check_val("xreg_o", 64'(xreg_o), 64'(x));
                end
        endtask

        task automatic drive_inputs(input bit fire);
                if (fire) begin
                        in_idx++;
                end
                if (!pipe_in_valid_i || fire) begin
                        pipe_in_valid_i = (in_idx < in_q.size()) && (($urandom % 4) != 0);
                        if (in_idx < in_q.size()) begin
                                pipe_in_i = in_q[in_idx];
                        end
                end
                pipe_out_ready_i = ($urandom % 4) != 0;
                instr_spec_i     = 8'($urandom & $urandom & $urandom);   // Short stalls
                instr_killed_i   = 8'($urandom & $urandom);
        endtask

        initial begin
                clk_i = 1'b0;
                forever #5 clk_i = ~clk_i;
        end

        initial begin
                void'($urandom(SEED));
                async_rst_ni     = 1'b0;
                pipe_in_valid_i  = 1'b0;
                pipe_in_i        = '0;
                pipe_out_ready_i = 1'b0;
                instr_spec_i     = '0;
                instr_killed_i   = '0;
                m_cnt            = '0;
                m_has_res        = 1'b0;
                build_stream();
                limit = beat_q.size() * 20 + 200;
                repeat (5) @(posedge clk_i);
                #1;
                async_rst_ni = 1'b1;
                while ((beat_q.size() != 0) && !timed_out) begin
                        // Handshakes of the coming edge, settled since the last drive
                        @(negedge clk_i);
                        cycles++;
                        in_fire  = pipe_in_valid_i && pipe_in_ready_o;
                        out_fire = pipe_out_valid_o && pipe_out_ready_i;
                        check_outputs(out_fire);
                        if (cycles > limit) begin
                                timed_out = 1'b1;
                                errors++;
                                $display("timeout after %0d cycles, %0d beats never arrived",
                                         cycles, beat_q.size());
                        end
                        @(posedge clk_i);
                        #1;
                        drive_inputs(in_fire);
                end
                $display("%0d beats checked in %0d cycles, %0d errors", beats, cycles, errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- vec_elem_unit.f
logic/vec_elem_pkg.sv
logic/pipe_reg.sv
logic/elem_op_stage.sv
logic/elem_result_packer.sv
logic/vec_elem_unit.sv
test/vec_elem_unit_sva.sv
test/vec_elem_unit_tb.sv
